//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // ------------------------------
    // opcodes, rv32i base encoding
    // ------------------------------
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 of the kept alu instructions
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // alu_op from the main decoder
    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_RTYPE,
        ALU_ITYPE
    } alu_op_e;

    // concrete alu operation after function decode
    typedef enum logic [2:0] {
        FN_ADD,
        FN_SUB,
        FN_AND,
        FN_OR,
        FN_SLT
    } alu_fn_e;

    // ------------------------------
    // control word, 8 bits
    // ------------------------------
    typedef struct packed {
        logic    branch;
        logic    alu_src;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    reg_write;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

//--- hdl/soc_map_pkg.sv
package soc_map_pkg;

    // ------------------------------
    // memory sizes
    // ------------------------------
    localparam int unsigned IMEM_WORDS = 64;
    localparam int unsigned IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int unsigned DMEM_WORDS = 256;
    localparam int unsigned DMEM_AW    = $clog2(DMEM_WORDS);

    // ------------------------------
    // i/o window, last 16 bytes
    // ------------------------------
    // upper 28 address bits all ones
    localparam logic [27:0] IO_BASE_HI = 28'hFFF_FFFF;
    // byte offsets inside the window
    localparam logic [3:0] IO_SWITCH = 4'h0;
    localparam logic [3:0] IO_LED    = 4'h4;
    localparam logic [3:0] IO_SEG    = 4'h8;

    // clocks per enabled display digit
    localparam int unsigned SCAN_DIV   = 4;
    localparam int unsigned SCAN_DIV_W = $clog2(SCAN_DIV);

    // store strobes towards the output block, 34 bits
    typedef struct packed {
        logic        led_we;
        logic        seg_we;
        logic [31:0] wdata;
    } io_wr_t;

endpackage

//--- hdl/ifetch.sv
module ifetch (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        branch_taken_i,
    input  logic [31:0] imm_i,
    output logic [31:0] instr_o,
    output logic [31:0] pc_plus4_o
);

    import soc_map_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] pc_next;
    logic [31:0] branch_target;

    // instruction rom, filled once at elaboration
    logic [31:0] rom [IMEM_WORDS];

    initial begin
        $readmemh("hdl/prog.hex", rom);
    end

    // ------------------------------
    // next pc
    // ------------------------------
    assign pc_plus4_o    = pc_q + 32'd4;
    // b-type offset is already sign extended and byte aligned
    assign branch_target = pc_q + imm_i;
    assign pc_next       = branch_taken_i ? branch_target : pc_plus4_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    // word index from pc, combinational read
    assign instr_o = rom[pc_q[IMEM_AW+1:2]];

endmodule

//--- hdl/controller.sv
module controller (
    input  logic               [31:0] instr_i,
    input  logic               [31:0] alu_result_i,
    input  logic                      zero_i,
    output rv_isa_pkg::ctrl_t         ctrl_o,
    output logic                      branch_taken_o,
    output logic                      io_read_o,
    output logic                      io_write_o
);

    import rv_isa_pkg::*;
    import soc_map_pkg::*;

    ctrl_t dec;
    logic  is_io;

    // ------------------------------
    // main decoder
    // ------------------------------
    always_comb begin
        dec = '0;
        case (instr_i[6:0])
            OP_RTYPE: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = ALU_RTYPE;
            end
            OP_ITYPE: begin
                dec.alu_src   = 1'b1;
                dec.reg_write = 1'b1;
                dec.alu_op    = ALU_ITYPE;
            end
            OP_LOAD: begin
                // address = rs1 + imm
                dec.alu_src    = 1'b1;
                dec.mem_read   = 1'b1;
                dec.mem_to_reg = 1'b1;
                dec.reg_write  = 1'b1;
                dec.alu_op     = ALU_ADD;
            end
            OP_STORE: begin
                dec.alu_src   = 1'b1;
                dec.mem_write = 1'b1;
                dec.alu_op    = ALU_ADD;
            end
            OP_BRANCH: begin
                // beq, compare by subtraction
                dec.branch = 1'b1;
                dec.alu_op = ALU_SUB;
            end
            default: begin
                dec = '0;
            end
        endcase
    end

    // ------------------------------
    // memory versus i/o split
    // ------------------------------
    // alu result is the effective address for loads and stores
    assign is_io = (alu_result_i[31:4] == IO_BASE_HI);

    always_comb begin
        ctrl_o           = dec;
        // i/o accesses never touch data memory
        ctrl_o.mem_read  = dec.mem_read & ~is_io;
        ctrl_o.mem_write = dec.mem_write & ~is_io;
    end

    assign io_read_o  = dec.mem_read & is_io;
    assign io_write_o = dec.mem_write & is_io;

    // taken when operands compared equal
    assign branch_taken_o = dec.branch & zero_i;

endmodule

//--- hdl/decoder.sv
module decoder (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic               [31:0] instr_i,
    input  rv_isa_pkg::ctrl_t         ctrl_i,
    input  logic               [31:0] alu_result_i,
    input  logic               [31:0] load_data_i,
    output logic               [31:0] rdata1_o,
    output logic               [31:0] rdata2_o,
    output logic               [31:0] imm_o
);

    import rv_isa_pkg::*;

    logic [31:0] regs [32];
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] wb_data;
    logic        wb_en;

    assign rs1 = instr_i[19:15];
    assign rs2 = instr_i[24:20];
    assign rd  = instr_i[11:7];

    // ------------------------------
    // register file
    // ------------------------------
    // write-back source, load or alu
    assign wb_data = ctrl_i.mem_to_reg ? load_data_i : alu_result_i;
    // x0 is hard wired
    assign wb_en   = ctrl_i.reg_write && (rd != 5'd0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[rd] <= wb_data;
        end
    end

    // reads are combinational
    assign rdata1_o = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2_o = (rs2 == 5'd0) ? '0 : regs[rs2];

    // ------------------------------
    // immediate generation
    // ------------------------------
    always_comb begin
        case (instr_i[6:0])
            OP_ITYPE, OP_LOAD: imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            OP_STORE:          imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            // b-type, lsb always zero
            OP_BRANCH: imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                instr_i[11:8], 1'b0};
            default:           imm_o = '0;
        endcase
    end

endmodule

//--- hdl/alu.sv
module alu (
    input  logic               [31:0] rdata1_i,
    input  logic               [31:0] rdata2_i,
    input  logic               [31:0] imm_i,
    input  rv_isa_pkg::ctrl_t         ctrl_i,
    input  logic               [31:0] instr_i,
    output logic               [31:0] result_o,
    output logic                      zero_o
);

    import rv_isa_pkg::*;

    alu_fn_e     fn;
    logic [2:0]  funct3;
    logic [31:0] op_b;

    assign funct3 = instr_i[14:12];

    // ------------------------------
    // alu control
    // ------------------------------
    always_comb begin
        fn = FN_ADD;
        case (ctrl_i.alu_op)
            ALU_ADD: fn = FN_ADD;
            ALU_SUB: fn = FN_SUB;
            ALU_RTYPE, ALU_ITYPE: begin
                case (funct3)
                    // funct7 bit 30 picks sub, r-type only
                    F3_ADD:  fn = (ctrl_i.alu_op == ALU_RTYPE && instr_i[30]) ? FN_SUB : FN_ADD;
                    F3_SLT:  fn = FN_SLT;
                    F3_OR:   fn = FN_OR;
                    F3_AND:  fn = FN_AND;
                    default: fn = FN_ADD;
                endcase
            end
            default: fn = FN_ADD;
        endcase
    end

    // ------------------------------
    // datapath
    // ------------------------------
    assign op_b = ctrl_i.alu_src ? imm_i : rdata2_i;

    always_comb begin
        case (fn)
            FN_SUB:  result_o = rdata1_i - op_b;
            FN_AND:  result_o = rdata1_i & op_b;
            FN_OR:   result_o = rdata1_i | op_b;
            // signed compare
            FN_SLT:  result_o = {31'd0, $signed(rdata1_i) < $signed(op_b)};
            default: result_o = rdata1_i + op_b;
        endcase
    end

    assign zero_o = (result_o == 32'd0);

endmodule

//--- hdl/dmem.sv
module dmem (
    input  logic                             clk,
    input  logic                             we_i,
    input  logic [soc_map_pkg::DMEM_AW-1:0]  addr_i,
    input  logic [31:0]                      wdata_i,
    output logic [31:0]                      rdata_o
);

    import soc_map_pkg::*;

    // word array, contents undefined until written
    logic [31:0] mem [DMEM_WORDS];

    // ------------------------------
    // write port
    // ------------------------------
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // read port, same cycle
    assign rdata_o = mem[addr_i];

endmodule

//--- hdl/mem_or_io.sv
module mem_or_io (
    input  rv_isa_pkg::ctrl_t                             ctrl_i,
    input  logic                                          io_read_i,
    input  logic                                          io_write_i,
    input  logic               [31:0]                     addr_i,
    input  logic               [31:0]                     store_data_i,
    input  logic               [31:0]                     mem_rdata_i,
    input  logic               [11:0]                     switch_i,
    output logic                                          mem_we_o,
    output logic               [soc_map_pkg::DMEM_AW-1:0] mem_addr_o,
    output logic               [31:0]                     load_data_o,
    output soc_map_pkg::io_wr_t                           io_wr_o
);

    import soc_map_pkg::*;

    logic [3:0] io_off;

    // device offset inside the i/o window
    assign io_off = addr_i[3:0];

    // ------------------------------
    // data memory side
    // ------------------------------
    // word index, byte offset dropped
    assign mem_addr_o = addr_i[DMEM_AW+1:2];
    // already cleared by the controller for i/o stores
    assign mem_we_o   = ctrl_i.mem_write;

    // ------------------------------
    // load steering
    // ------------------------------
    always_comb begin
        load_data_o = '0;
        if (io_read_i) begin
            // only the switch port reads back, zero extended
            if (io_off == IO_SWITCH) begin
                load_data_o = {20'd0, switch_i};
            end
        end else if (ctrl_i.mem_read) begin
            load_data_o = mem_rdata_i;
        end
    end

    // ------------------------------
    // store strobes
    // ------------------------------
    always_comb begin
        io_wr_o        = '0;
        io_wr_o.led_we = io_write_i && (io_off == IO_LED);
        io_wr_o.seg_we = io_write_i && (io_off == IO_SEG);
        // store data rides along with either strobe
        io_wr_o.wdata  = store_data_i;
    end

endmodule

//--- hdl/led_con.sv
module led_con (
    input  logic                       clk,
    input  logic                       reset_i,
    input  soc_map_pkg::io_wr_t        io_wr_i,
    output logic                [15:0] led_o,
    output logic                [7:0]  digit_en_o,
    output logic                [7:0]  sseg_o
);

    import soc_map_pkg::*;

    logic [31:0]           seg_q;
    logic [SCAN_DIV_W-1:0] div_q;
    logic [2:0]            digit_q;
    logic                  scan_on_q;
    logic                  tick;
    logic [3:0]            nibble;
    logic [6:0]            pattern;

    // ------------------------------
    // output registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            led_o <= '0;
            seg_q <= '0;
        end else begin
            // led keeps the low half of the write
            if (io_wr_i.led_we) begin
                led_o <= io_wr_i.wdata[15:0];
            end
            if (io_wr_i.seg_we) begin
                seg_q <= io_wr_i.wdata;
            end
        end
    end

    // ------------------------------
    // digit scan
    // ------------------------------
    assign tick = (div_q == SCAN_DIV_W'(SCAN_DIV - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            div_q     <= '0;
            digit_q   <= '0;
            scan_on_q <= 1'b0;
        end else begin
            div_q <= tick ? '0 : div_q + 1'b1;
            // first period only turns the display on, digit 0 next
            if (tick) begin
                scan_on_q <= 1'b1;
                if (scan_on_q) begin
                    digit_q <= digit_q + 3'd1;
                end
            end
        end
    end

    // enabled digit k shows nibble k
    assign nibble = seg_q[{digit_q, 2'b00} +: 4];

    // hex to segments, bit 0 = a .. bit 6 = g
    always_comb begin
        case (nibble)
            4'h0: pattern = 7'h3F;
            4'h1: pattern = 7'h06;
            4'h2: pattern = 7'h5B;
            4'h3: pattern = 7'h4F;
            4'h4: pattern = 7'h66;
            4'h5: pattern = 7'h6D;
            4'h6: pattern = 7'h7D;
            4'h7: pattern = 7'h07;
            4'h8: pattern = 7'h7F;
            4'h9: pattern = 7'h6F;
            4'hA: pattern = 7'h77;
            4'hB: pattern = 7'h7C;
            4'hC: pattern = 7'h39;
            4'hD: pattern = 7'h5E;
            4'hE: pattern = 7'h79;
            default: pattern = 7'h71;
        endcase
    end

    // one-hot enable, dark before scanning starts
    assign digit_en_o = scan_on_q ? (8'b1 << digit_q) : 8'd0;
    // decimal point unused
    assign sseg_o     = scan_on_q ? {1'b0, pattern} : 8'd0;

endmodule

//--- hdl/cpu_top.sv
module cpu_top (
    input  logic        clk,
    input  logic        reset_i,
    input  logic [11:0] switch_i,
    output logic [15:0] led_o,
    output logic [7:0]  digit_en_o,
    output logic [7:0]  sseg_o
);

    import rv_isa_pkg::*;
    import soc_map_pkg::*;

    // fetch and decode
    logic [31:0]        instr;
    ctrl_t              ctrl;
    logic               branch_taken;
    logic               io_read;
    logic               io_write;
    logic [31:0]        rdata1;
    logic [31:0]        rdata2;
    logic [31:0]        imm;
    // execute
    logic [31:0]        alu_result;
    logic               zero;
    // memory and i/o
    logic               mem_we;
    logic [DMEM_AW-1:0] mem_addr;
    logic [31:0]        mem_rdata;
    logic [31:0]        load_data;
    io_wr_t             io_wr;

    // ------------------------------
    // fetch, control, register file
    // ------------------------------
    // no jumps, so pc + 4 has no consumer
    ifetch u_ifetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .branch_taken_i (branch_taken),
        .imm_i          (imm),
        .instr_o        (instr),
        .pc_plus4_o     ()
    );

    controller u_controller (
        .instr_i        (instr),
        .alu_result_i   (alu_result),
        .zero_i         (zero),
        .ctrl_o         (ctrl),
        .branch_taken_o (branch_taken),
        .io_read_o      (io_read),
        .io_write_o     (io_write)
    );

    decoder u_decoder (
        .clk          (clk),
        .reset_i      (reset_i),
        .instr_i      (instr),
        .ctrl_i       (ctrl),
        .alu_result_i (alu_result),
        .load_data_i  (load_data),
        .rdata1_o     (rdata1),
        .rdata2_o     (rdata2),
        .imm_o        (imm)
    );

    // ------------------------------
    // execute
    // ------------------------------
    alu u_alu (
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .imm_i    (imm),
        .ctrl_i   (ctrl),
        .instr_i  (instr),
        .result_o (alu_result),
        .zero_o   (zero)
    );

    // ------------------------------
    // memory, i/o steering, outputs
    // ------------------------------
    // alu result is the effective address, rs2 the store data
    mem_or_io u_mem_or_io (
        .ctrl_i       (ctrl),
        .io_read_i    (io_read),
        .io_write_i   (io_write),
        .addr_i       (alu_result),
        .store_data_i (rdata2),
        .mem_rdata_i  (mem_rdata),
        .switch_i     (switch_i),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .load_data_o  (load_data),
        .io_wr_o      (io_wr)
    );

    // word index is address bits 9 to 2
    dmem u_dmem (
        .clk     (clk),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (rdata2),
        .rdata_o (mem_rdata)
    );

    led_con u_led_con (
        .clk        (clk),
        .reset_i    (reset_i),
        .io_wr_i    (io_wr),
        .led_o      (led_o),
        .digit_en_o (digit_en_o),
        .sseg_o     (sseg_o)
    );

endmodule

//--- dv/cpu_tb.sv
module cpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import soc_map_pkg::*;

    localparam int unsigned WAIT_LIMIT  = 200;
    localparam int unsigned ACK_LIMIT   = 1000;
    localparam int unsigned SCAN_WINDOW = 8 * SCAN_DIV * 2;
    localparam int unsigned HOLD_CYCLES = 100;
    localparam int          NUM_FIXED   = 6;
    localparam int          NUM_TESTS   = NUM_FIXED + 20;

    // expected outputs for one switch value
    typedef struct packed {
        logic [15:0] led;
        logic [31:0] seg;
    } expect_t;

    logic        clk;
    logic        reset_i;
    logic [11:0] switch_i;
    logic [15:0] led_o;
    logic [7:0]  digit_en_o;
    logic [7:0]  sseg_o;

    // handoff from stimulus to checker
    logic [11:0] req_s;
    int          req_cnt  = 0;
    int          ack_cnt  = 0;
    int unsigned n_checks = 0;
    int unsigned n_errors = 0;
    integer      seed;

    cpu_top u_cpu_top (
        .clk        (clk),
        .reset_i    (reset_i),
        .switch_i   (switch_i),
        .led_o      (led_o),
        .digit_en_o (digit_en_o),
        .sseg_o     (sseg_o)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic expect_t ref_outputs(input logic [11:0] s);
        expect_t     e;
        logic [31:0] s32;
        s32   = {20'd0, s};
        e.led = 16'(s32 + 32'h123);
        // below 0x100 shows s - 7, wraps for small s
        if (s32 < 32'h100) begin
            e.seg = s32 - 32'd7;
        end else begin
            e.seg = s32 | 32'h800;
        end
        return e;
    endfunction

    // hex digit patterns, bit 0 = a .. bit 6 = g, dp off
    function automatic logic [7:0] seg_pattern(input logic [3:0] n);
        case (n)
            4'h0: return 8'b0011_1111;
            4'h1: return 8'b0000_0110;
            4'h2: return 8'b0101_1011;
            4'h3: return 8'b0100_1111;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b0110_1101;
            4'h6: return 8'b0111_1101;
            4'h7: return 8'b0000_0111;
            4'h8: return 8'b0111_1111;
            4'h9: return 8'b0110_1111;
            4'hA: return 8'b0111_0111;
            4'hB: return 8'b0111_1100;
            4'hC: return 8'b0011_1001;
            4'hD: return 8'b0101_1110;
            4'hE: return 8'b0111_1001;
            default: return 8'b0111_0001;
        endcase
    endfunction

    // pattern back to nibble, bit 4 set for a legal pattern
    function automatic logic [4:0] decode_digit(input logic [7:0] p);
        logic [4:0] r;
        r = 5'd0;
        for (int n = 0; n < 16; n++) begin
            if (seg_pattern(4'(n)) == p) begin
                r = {1'b1, 4'(n)};
            end
        end
        return r;
    endfunction

    // ------------------------------
    // error reporting
    // ------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                 $time, name, exp_v, act_v);
        n_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR time=%0t %s", $time, msg);
        n_errors++;
    endtask

    // ------------------------------
    // checker tasks
    // ------------------------------
    task automatic check_quiet_outputs();
        n_checks += 2;
        assert (led_o == 16'd0) else report_mismatch("led_o", 32'd0, {16'd0, led_o});
        assert (digit_en_o == 8'd0)
            else report_mismatch("digit_en_o", 32'd0, {24'd0, digit_en_o});
    endtask

    // outputs quiet during reset and on the first cycle after it
    task automatic check_reset_state();
        int unsigned waited;
        waited = 0;
        @(negedge clk);
        while (reset_i && waited < WAIT_LIMIT) begin
            check_quiet_outputs();
            @(negedge clk);
            waited++;
        end
        if (reset_i) begin
            report_problem("reset_i was never released");
        end else begin
            check_quiet_outputs();
        end
    endtask

    task automatic wait_led(input logic [15:0] exp_led);
        int unsigned waited;
        waited = 0;
        while (led_o !== exp_led && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (led_o !== exp_led) begin
            report_problem("led_o did not reach the expected value in time");
        end
        n_checks++;
        assert (led_o == exp_led)
            else report_mismatch("led_o", {16'd0, exp_led}, {16'd0, led_o});
    endtask

    // rebuild the shown value digit by digit until a full frame matches
    task automatic wait_seg_value(input logic [31:0] exp_seg);
        logic [31:0] shown;
        logic [7:0]  seen;
        logic [7:0]  bad;
        logic [4:0]  dec;
        int unsigned k;
        int unsigned waited;
        bit          done;
        shown  = '0;
        seen   = '0;
        bad    = '0;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            if ($onehot(digit_en_o)) begin
                k                 = $clog2(digit_en_o);
                dec               = decode_digit(sseg_o);
                seen[k]           = 1'b1;
                bad[k]            = ~dec[4];
                shown[4*k +: 4]   = dec[3:0];
            end
            done = (seen == 8'hFF) && (bad == 8'h00) && (shown == exp_seg);
        end
        if (!done) begin
            report_problem("display never showed the expected segment value");
        end
        n_checks++;
        assert (shown == exp_seg) else report_mismatch("segment value", exp_seg, shown);
    endtask

    // one-hot enables, every position visited, pattern per digit
    task automatic check_scan(input logic [31:0] exp_seg);
        logic [7:0]  seen;
        int unsigned k;
        seen = '0;
        for (int c = 0; c < SCAN_WINDOW; c++) begin
            @(negedge clk);
            n_checks++;
            assert ($onehot(digit_en_o))
                else report_problem($sformatf("digit_en_o is not one-hot: %b", digit_en_o));
            if ($onehot(digit_en_o)) begin
                k       = $clog2(digit_en_o);
                seen[k] = 1'b1;
                n_checks++;
                assert (sseg_o == seg_pattern(exp_seg[4*k +: 4]))
                    else report_mismatch("sseg_o", {24'd0, seg_pattern(exp_seg[4*k +: 4])},
                                         {24'd0, sseg_o});
            end
        end
        n_checks++;
        assert (seen == 8'hFF) else report_problem("not all eight digits were scanned");
    endtask

    task automatic check_hold(input logic [15:0] exp_led);
        for (int c = 0; c < HOLD_CYCLES; c++) begin
            @(negedge clk);
            n_checks++;
            assert (led_o == exp_led)
                else report_mismatch("led_o", {16'd0, exp_led}, {16'd0, led_o});
        end
    endtask

    // ------------------------------
    // compare process
    // ------------------------------
    initial begin : compare_loop
        expect_t     e;
        int unsigned waited;
        check_reset_state();
        for (int t = 0; t < NUM_TESTS; t++) begin
            waited = 0;
            while (req_cnt == t && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (req_cnt == t) begin
                report_problem("no new switch value arrived from the stimulus");
            end else begin
                e = ref_outputs(req_s);
                wait_led(e.led);
                wait_seg_value(e.seg);
                check_scan(e.seg);
                check_hold(e.led);
            end
            ack_cnt <= t + 1;
        end
        $display("checks=%0d errors=%0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // ------------------------------
    // stimulus, driven on falling edges
    // ------------------------------
    initial begin : drive_loop
        logic [11:0] fixed_vals [NUM_FIXED];
        logic [11:0] s;
        int unsigned waited;
        fixed_vals = '{12'h005, 12'h0FF, 12'h000, 12'h100, 12'hABC, 12'hFFF};
        seed       = 32'h4309;
        reset_i    = 1'b1;
        switch_i   = 12'h000;
        req_s      = 12'h000;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i <= 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            // low and high path corners first, then random tracking
            if (t < NUM_FIXED) begin
                s = fixed_vals[t];
            end else begin
                s = 12'($random(seed));
            end
            @(negedge clk);
            switch_i <= s;
            req_s    <= s;
            req_cnt  <= t + 1;
            waited = 0;
            while (ack_cnt != t + 1 && waited < ACK_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (ack_cnt != t + 1) begin
                report_problem("checker did not finish the current switch value");
            end
        end
    end

endmodule

//--- hdl/prog.hex
// one instruction word per line, line n holds byte address 4*n
ff000093  // addi x1, x0, -16     i/o window base, switch address
40000413  // addi x8, x0, 0x400
00840433  // add  x8, x8, x8      x8 = 0x800, too wide for an immediate
0000a103  // loop: lw x2, 0(x1)   s from the switches
00202823  // sw   x2, 16(x0)
01002183  // lw   x3, 16(x0)      reload through data memory
12318213  // addi x4, x3, 0x123
0040a223  // sw   x4, 4(x1)       led
10000293  // addi x5, x0, 0x100
0051a333  // slt  x6, x3, x5
00030863  // beq  x6, x0, high
ff918393  // addi x7, x3, -7
0070a423  // sw   x7, 8(x1)       segment value
fc000ce3  // beq  x0, x0, loop
0081e3b3  // high: or x7, x3, x8
0070a423  // sw   x7, 8(x1)       segment value
fc0006e3  // beq  x0, x0, loop

//--- compile.f
hdl/rv_isa_pkg.sv
hdl/soc_map_pkg.sv
hdl/ifetch.sv
hdl/controller.sv
hdl/decoder.sv
hdl/alu.sv
hdl/dmem.sv
hdl/mem_or_io.sv
hdl/led_con.sv
hdl/cpu_top.sv
dv/cpu_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module cpu_top

obj_dir/Vcpu_tb: compile.f $(wildcard hdl/*.sv) hdl/prog.hex dv/cpu_tb.sv
	verilator --binary --timing --assert -f compile.f --top-module cpu_tb -o Vcpu_tb

sim: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
